//--- btn_debounce.sv
`timescale 1ns/1ps

module btn_debounce (
	input  logic clk,
	input  logic rst,
	input  logic btn_i,   // raw pin
	output logic btn_o    // filtered level
);
	import soc_pkg::*;

	logic btn_meta;   // first sync stage
	logic btn_sync;   // safe to use
	logic [$clog2(DEBOUNCE_CYCLES)-1:0] cnt;  // cycles the input has differed

	// two flops against metastability
	always_ff @(posedge clk) begin
		btn_meta <= btn_i;
		btn_sync <= btn_meta;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt   <= '0;
			btn_o <= 1'b0;
		end else if (btn_sync == btn_o) begin
			cnt <= '0;              // agrees again, start over
		end else if (cnt == DEBOUNCE_CYCLES - 1) begin
			btn_o <= btn_sync;      // held long enough
			cnt   <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

//--- bus_timeout.sv
`timescale 1ns/1ps

module bus_timeout (
	input  logic clk,
	input  logic rst,
	input  logic cyc_i,
	input  logic stb_i,
	input  logic ack_i,   // merged slave ack
	output logic err_o    // one-cycle bus error
);
	import soc_pkg::*;

	logic [$clog2(BUS_TIMEOUT)-1:0] cnt;  // cycles waited so far

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt   <= '0;
			err_o <= 1'b0;
		end else begin
			err_o <= 1'b0;
			if (!cyc_i || ack_i || err_o) begin
				cnt <= '0;                 // cycle over or answered
			end else if (stb_i) begin
				if (cnt == BUS_TIMEOUT - 1) begin
					err_o <= 1'b1;         // nobody home
					cnt   <= '0;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

endmodule

//--- io_bridge.sv
`timescale 1ns/1ps

module io_bridge (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      s_cyc_i,
	input  logic                      s_stb_i,
	input  logic                      s_we_i,
	input  logic                      s_cs_i,    // decode hit from top
	input  logic [soc_pkg::ADR_W-1:0] s_adr_i,
	input  logic [soc_pkg::BUS_W-1:0] s_dat_i,
	output logic                      s_ack_o,
	output logic [soc_pkg::BUS_W-1:0] s_dat_o,
	output logic                      io_cyc_o,
	output logic                      io_stb_o,
	output logic                      io_we_o,
	output logic [7:0]                io_adr_o,
	output logic [soc_pkg::IO_W-1:0]  io_dat_o,
	input  logic                      io_ack_i,
	input  logic [soc_pkg::IO_W-1:0]  io_dat_i
);
	import soc_pkg::*;

	// fsm, one flop per state, idle when none is set
	logic issue_q;   // strobe on the i/o side
	logic resp_q;    // ack toward the master
	logic hold_q;    // wait for release, or for timeout on a miss
	logic idle;
	logic start;

	logic [$clog2(LANES)-1:0] lane_q;   // adr[3:2] of this access
	bus_word_u                wr_word;
	bus_word_u                rd_word;

	assign idle  = ~(issue_q | resp_q | hold_q);
	assign start = idle & s_cyc_i & s_stb_i & s_cs_i;

	always_comb begin
		wr_word.word         = s_dat_i;
		rd_word              = '0;        // unused lanes read zero
		rd_word.lane[lane_q] = io_dat_i;
	end

	always_ff @(posedge clk) begin
		if (rst || !s_cyc_i) begin
			issue_q <= 1'b0;              // master gone, back to idle
			resp_q  <= 1'b0;
			hold_q  <= 1'b0;
		end else begin
			issue_q <= start;             // single strobe
			resp_q  <= issue_q & io_ack_i;
			hold_q  <= (issue_q & ~io_ack_i) | resp_q | (hold_q & s_stb_i);
		end
	end

	// address and write lane latched at the request edge
	always_ff @(posedge clk) begin
		if (start) begin
			io_adr_o <= s_adr_i[11:4];
			io_we_o  <= s_we_i;
			io_dat_o <= wr_word.lane[s_adr_i[3:2]];  // byte selects ignored
			lane_q   <= s_adr_i[3:2];
		end
		if (issue_q)
			s_dat_o <= rd_word.word;       // read data back in its lane
	end

	assign io_cyc_o = issue_q;
	assign io_stb_o = issue_q;
	assign s_ack_o  = resp_q;

endmodule

//--- io_regs.sv
`timescale 1ns/1ps

module io_regs (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           io_cyc_i,
	input  logic                           io_stb_i,
	input  logic                           io_we_i,
	input  logic [7:0]                     io_adr_i,   // adr[11:4]
	input  logic [soc_pkg::IO_W-1:0]       io_dat_i,
	output logic                           io_ack_o,
	output logic [soc_pkg::IO_W-1:0]       io_dato_o,
	input  logic [15:0]                    sw_i,
	input  logic [soc_pkg::NUM_BTNS-1:0]   btn_i,
	output logic [15:0]                    led_o,
	output logic [soc_pkg::NUM_DIGITS-1:0] an_o,
	output logic [7:0]                     ssg_o
);
	import soc_pkg::*;

	logic [NUM_BTNS-1:0] btn_db;  // filtered, same order as btn_i
	logic [IO_W-1:0]     sseg_q;  // value on the display
	logic                hit_led;
	logic                hit_sseg;
	logic                hit_btn;

	// -------------------------------------------------------------------
	// decode, ack in the strobe cycle
	// -------------------------------------------------------------------
	assign hit_led  = io_cyc_i & io_stb_i & (io_adr_i == LED_OFS);
	assign hit_sseg = io_cyc_i & io_stb_i & (io_adr_i == SSEG_OFS);
	assign hit_btn  = io_cyc_i & io_stb_i & (io_adr_i == BTN_OFS);
	assign io_ack_o = hit_led | hit_sseg | hit_btn;  // nothing else answers

	// read mux, display reads back as zero
	always_comb begin
		io_dato_o = '0;
		if (hit_led)
			io_dato_o = {{(IO_W-16){1'b0}}, sw_i};        // switches, not leds
		else if (hit_btn)
			io_dato_o = {{(IO_W-NUM_BTNS){1'b0}}, btn_db};
	end

	// -------------------------------------------------------------------
	// write side
	// -------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			led_o  <= '0;
			sseg_q <= '0;
		end else if (io_we_i) begin
			if (hit_led)
				led_o <= io_dat_i[15:0];
			if (hit_sseg)
				sseg_q <= io_dat_i;
			// button writes dropped
		end
	end

	// one filter per button
	for (genvar i = 0; i < NUM_BTNS; i++) begin : g_btn
		btn_debounce i_db (
			.clk   (clk),
			.rst   (rst),
			.btn_i (btn_i[i]),
			.btn_o (btn_db[i])
		);
	end

	seven_seg_driver i_sseg (
		.clk   (clk),
		.rst   (rst),
		.val_i (sseg_q),
		.an_o  (an_o),
		.ssg_o (ssg_o)
	);

endmodule

//--- project.f
soc_pkg.sv
btn_debounce.sv
seven_seg_driver.sv
io_regs.sv
io_bridge.sv
scratch_ram.sv
bus_timeout.sv
soc_top.sv
soc_props.sv
tb_soc.sv

//--- scratch_ram.sv
`timescale 1ns/1ps

module scratch_ram (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             cyc_i,
	input  logic                             stb_i,
	input  logic                             cs_i,
	input  logic                             we_i,
	input  logic [soc_pkg::SEL_W-1:0]        sel_i,  // byte enables
	input  logic [soc_pkg::SCR_ADR_BITS-1:0] adr_i,  // word address
	input  logic [soc_pkg::BUS_W-1:0]        dat_i,
	output logic                             ack_o,
	output logic [soc_pkg::BUS_W-1:0]        dat_o
);
	import soc_pkg::*;

	logic [BUS_W-1:0] mem [0:(1 << SCR_ADR_BITS)-1];  // 16 KB
	logic             req;

	// no new request while our ack is still out
	assign req = cyc_i & stb_i & cs_i & ~ack_o;

	always_ff @(posedge clk) begin
		if (rst)
			ack_o <= 1'b0;
		else
			ack_o <= req;   // one cycle later, one cycle long
	end

	// byte-lane writes, whole word read
	always_ff @(posedge clk) begin
		if (req) begin
			for (int i = 0; i < SEL_W; i++) begin
				if (we_i && sel_i[i])
					mem[adr_i][i*8 +: 8] <= dat_i[i*8 +: 8];
			end
			dat_o <= mem[adr_i];   // old word on a write
		end
	end

endmodule

//--- seven_seg_driver.sv
`timescale 1ns/1ps

module seven_seg_driver (
	input  logic                             clk,
	input  logic                             rst,
	input  logic [4*soc_pkg::NUM_DIGITS-1:0] val_i,  // one hex nibble per digit
	output logic [soc_pkg::NUM_DIGITS-1:0]   an_o,   // active low anodes
	output logic [7:0]                       ssg_o   // active low, bit 7 = dp
);
	import soc_pkg::*;

	logic [SCAN_BITS-1:0]          pre;     // scan prescaler
	logic [$clog2(NUM_DIGITS)-1:0] dig;     // digit being lit
	logic [3:0]                    nib;
	logic [6:0]                    seg;     // active high, g..a
	logic [NUM_DIGITS-1:0]         dig_oh;  // one-hot digit

	assign nib = val_i[dig*4 +: 4];

	// hex font
	always_comb begin
		case (nib)
			4'h0: seg = 7'h3F;
			4'h1: seg = 7'h06;
			4'h2: seg = 7'h5B;
			4'h3: seg = 7'h4F;
			4'h4: seg = 7'h66;
			4'h5: seg = 7'h6D;
			4'h6: seg = 7'h7D;
			4'h7: seg = 7'h07;
			4'h8: seg = 7'h7F;
			4'h9: seg = 7'h6F;
			4'hA: seg = 7'h77;
			4'hB: seg = 7'h7C;  // lower case b
			4'hC: seg = 7'h39;
			4'hD: seg = 7'h5E;  // lower case d
			4'hE: seg = 7'h79;
			default: seg = 7'h71;
		endcase
	end

	always_comb begin
		dig_oh      = '0;
		dig_oh[dig] = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pre   <= '0;
			dig   <= '0;
			an_o  <= ~{{(NUM_DIGITS-1){1'b0}}, 1'b1};  // digit 0 first
			ssg_o <= {1'b1, ~7'h3F};                   // shows a zero
		end else begin
			pre <= pre + 1'b1;
			if (&pre)
				dig <= dig + 1'b1;  // next digit on wrap
			// anode and segments leave the same stage
			an_o  <= ~dig_oh;
			ssg_o <= {1'b1, ~seg};  // dp kept dark
		end
	end

endmodule

//--- soc_pkg.sv
package soc_pkg;

	// -------------------------------------------------------------------
	// master bus geometry
	// -------------------------------------------------------------------
	localparam int BUS_W = 128;     // master data width
	localparam int ADR_W = 32;      // byte address
	localparam int SEL_W = 16;      // one select per byte lane
	localparam int IO_W  = 32;      // i/o side data width
	localparam int LANES = 4;       // 32-bit lanes per bus word

	// -------------------------------------------------------------------
	// address map
	// -------------------------------------------------------------------
	localparam int SCR_ADR_BITS = 10;             // 1024 words of 16 bytes
	localparam logic [17:0] SCR_TAG = 18'h00000;  // adr[31:14]
	localparam logic [19:0] IO_TAG  = 20'hFFDC0;  // adr[31:12]

	// register offsets, adr[11:4]
	localparam logic [7:0] LED_OFS  = 8'h06;  // leds out, switches in
	localparam logic [7:0] SSEG_OFS = 8'h00;  // display data
	localparam logic [7:0] BTN_OFS  = 8'h09;  // debounced buttons

	localparam int NUM_BTNS   = 5;
	localparam int NUM_DIGITS = 8;

	// timing
	localparam int DEBOUNCE_CYCLES = 16;  // stable cycles before a change
	localparam int SCAN_BITS       = 4;   // prescaler, 16 clocks per digit
	localparam int BUS_TIMEOUT     = 64;  // unacked cycles before err

	// one bus word, seen flat or as four i/o lanes
	typedef union packed {
		logic [BUS_W-1:0]           word;
		logic [LANES-1:0][IO_W-1:0] lane;  // lane 0 in bits 31..0
	} bus_word_u;

endpackage

//--- soc_props.sv
`timescale 1ns/1ps

module soc_props (
	input logic                           clk,
	input logic                           rst,
	input logic                           ack_i,
	input logic                           err_i,
	input logic [soc_pkg::NUM_DIGITS-1:0] an_i,
	input logic [15:0]                    led_i
);

	int fail_cnt = 0;  // failed properties so far

	// -------------------------------------------------------------------
	// bus handshake
	// -------------------------------------------------------------------
	a_ack_err_excl: assert property (@(posedge clk) disable iff (rst) !(ack_i && err_i))
	else begin
		$error("ack and err high in the same cycle");
		fail_cnt++;
	end

	a_ack_single: assert property (@(posedge clk) disable iff (rst) ack_i |=> !ack_i)
	else begin
		$error("ack held for two cycles");
		fail_cnt++;
	end

	// display and leds
	a_one_anode: assert property (@(posedge clk) disable iff (rst) $countones(~an_i) == 1)
	else begin
		$error("anode count low is not one");
		fail_cnt++;
	end

	a_led_reset: assert property (@(posedge clk) rst |=> (led_i == '0))
	else begin
		$error("leds not cleared by reset");
		fail_cnt++;
	end

endmodule

bind soc_top soc_props i_props (
	.clk   (clk),
	.rst   (rst),
	.ack_i (ack_o),
	.err_i (err_o),
	.an_i  (an_o),
	.led_i (led_o)
);

//--- soc_top.sv
`timescale 1ns/1ps

module soc_top (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           cyc_i,
	input  logic                           stb_i,
	input  logic                           we_i,
	input  logic [soc_pkg::SEL_W-1:0]      sel_i,
	input  logic [soc_pkg::ADR_W-1:0]      adr_i,
	input  logic [soc_pkg::BUS_W-1:0]      dat_i,
	output logic [soc_pkg::BUS_W-1:0]      dat_o,
	output logic                           ack_o,
	output logic                           err_o,
	input  logic [15:0]                    sw_i,
	input  logic [soc_pkg::NUM_BTNS-1:0]   btn_i,
	output logic [15:0]                    led_o,
	output logic [soc_pkg::NUM_DIGITS-1:0] an_o,
	output logic [7:0]                     ssg_o
);
	import soc_pkg::*;

	logic             cs_scr;   // scratch ram window
	logic             cs_io;    // i/o bridge window
	logic             scr_ack;
	logic [BUS_W-1:0] scr_dat;
	logic             br_ack;
	logic [BUS_W-1:0] br_dat;

	// 32-bit i/o bus
	logic             io_cyc;
	logic             io_stb;
	logic             io_we;
	logic [7:0]       io_adr;
	logic [IO_W-1:0]  io_dat;
	logic             io_ack;
	logic [IO_W-1:0]  io_dato;

	// -------------------------------------------------------------------
	// address decode and return path
	// -------------------------------------------------------------------
	assign cs_scr = (adr_i[ADR_W-1:14] == SCR_TAG);
	assign cs_io  = (adr_i[ADR_W-1:12] == IO_TAG);
	assign ack_o  = scr_ack | br_ack;
	assign dat_o  = cs_scr ? scr_dat : br_dat;

	scratch_ram i_ram (
		.clk   (clk),
		.rst   (rst),
		.cyc_i (cyc_i),
		.stb_i (stb_i),
		.cs_i  (cs_scr),
		.we_i  (we_i),
		.sel_i (sel_i),
		.adr_i (adr_i[SCR_ADR_BITS+3:4]),  // 16-byte words
		.dat_i (dat_i),
		.ack_o (scr_ack),
		.dat_o (scr_dat)
	);

	io_bridge i_bridge (
		.clk      (clk),
		.rst      (rst),
		.s_cyc_i  (cyc_i),
		.s_stb_i  (stb_i),
		.s_we_i   (we_i),
		.s_cs_i   (cs_io),
		.s_adr_i  (adr_i),
		.s_dat_i  (dat_i),
		.s_ack_o  (br_ack),
		.s_dat_o  (br_dat),
		.io_cyc_o (io_cyc),
		.io_stb_o (io_stb),
		.io_we_o  (io_we),
		.io_adr_o (io_adr),
		.io_dat_o (io_dat),
		.io_ack_i (io_ack),
		.io_dat_i (io_dato)
	);

	io_regs i_regs (
		.clk       (clk),
		.rst       (rst),
		.io_cyc_i  (io_cyc),
		.io_stb_i  (io_stb),
		.io_we_i   (io_we),
		.io_adr_i  (io_adr),
		.io_dat_i  (io_dat),
		.io_ack_o  (io_ack),
		.io_dato_o (io_dato),
		.sw_i      (sw_i),
		.btn_i     (btn_i),
		.led_o     (led_o),
		.an_o      (an_o),
		.ssg_o     (ssg_o)
	);

	// watchdog on the master side
	bus_timeout i_timeout (
		.clk   (clk),
		.rst   (rst),
		.cyc_i (cyc_i),
		.stb_i (stb_i),
		.ack_i (ack_o),
		.err_o (err_o)
	);

endmodule

//--- tb_soc.sv
`timescale 1ns/1ps

module tb_soc;
	import soc_pkg::*;

	localparam int WAIT_MAX = BUS_TIMEOUT + 16;                   // err deadline plus margin
	localparam int SCAN_LEN = 2 * NUM_DIGITS * (1 << SCAN_BITS);  // two full sweeps
	// hex font, segments g..a active high, digit F first
	localparam logic [16*7-1:0] FONT = {7'h71, 7'h79, 7'h5E, 7'h39, 7'h7C, 7'h77, 7'h6F, 7'h7F,
		7'h07, 7'h7D, 7'h6D, 7'h66, 7'h4F, 7'h5B, 7'h06, 7'h3F};

	logic                  clk;
	logic                  rst;
	logic                  cyc;
	logic                  stb;
	logic                  we;
	logic [SEL_W-1:0]      sel;
	logic [ADR_W-1:0]      adr;
	logic [BUS_W-1:0]      wdat;
	logic [BUS_W-1:0]      rdat;
	logic                  ack;
	logic                  err;
	logic [15:0]           sw;
	logic [NUM_BTNS-1:0]   btn;
	logic [15:0]           led;
	logic [NUM_DIGITS-1:0] an;
	logic [7:0]            ssg;

	logic [BUS_W-1:0]    ram_model [0:(1 << SCR_ADR_BITS)-1];
	logic [NUM_BTNS-1:0] btn_model;    // level the filters should settle to
	logic [BUS_W-1:0]    got_q [$];    // pending comparisons
	logic [BUS_W-1:0]    exp_q [$];
	string               what_q [$];
	logic [BUS_W-1:0]    last_rd;      // results of the last bus cycle
	int                  last_lat;
	logic                last_ack;
	logic                last_err;
	int                  mismatches = 0;
	int                  other_errs = 0;

	soc_top i_dut (
		.clk   (clk),
		.rst   (rst),
		.cyc_i (cyc),
		.stb_i (stb),
		.we_i  (we),
		.sel_i (sel),
		.adr_i (adr),
		.dat_i (wdat),
		.dat_o (rdat),
		.ack_o (ack),
		.err_o (err),
		.sw_i  (sw),
		.btn_i (btn),
		.led_o (led),
		.an_o  (an),
		.ssg_o (ssg)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;  // 40 ns period
	end

	// -------------------------------------------------------------------
	// reference model
	// -------------------------------------------------------------------
	function automatic logic [BUS_W-1:0] expected_read(input logic [ADR_W-1:0] a);
		bus_word_u       w;
		logic [IO_W-1:0] v;
		w = '0;
		v = '0;
		if (a[ADR_W-1:14] == SCR_TAG)
			return ram_model[a[SCR_ADR_BITS+3:4]];
		if (a[11:4] == LED_OFS)
			v = {16'h0000, sw};                           // switches, not leds
		else if (a[11:4] == BTN_OFS)
			v = {{(IO_W-NUM_BTNS){1'b0}}, btn_model};
		w.lane[a[3:2]] = v;                               // display reads zero
		return w.word;
	endfunction

	function automatic logic [7:0] expected_seg(input logic [3:0] nib);
		return {1'b1, ~FONT[nib*7 +: 7]};  // dp dark, active low
	endfunction

	function automatic logic [ADR_W-1:0] ram_addr(input logic [SCR_ADR_BITS-1:0] w);
		return {SCR_TAG, w, 4'h0};
	endfunction

	function automatic logic [ADR_W-1:0] io_addr(input logic [7:0] ofs, input logic [1:0] ln);
		return {IO_TAG, ofs, ln, 2'b00};
	endfunction

	function automatic logic [BUS_W-1:0] rand_word();
		return {$urandom, $urandom, $urandom, $urandom};
	endfunction

	task automatic queue_check(input logic [BUS_W-1:0] got, input logic [BUS_W-1:0] exp,
			input string what);
		got_q.push_back(got);
		exp_q.push_back(exp);
		what_q.push_back(what);
	endtask

	// one classic master cycle, ends on ack or err
	task automatic bus_cycle(input logic wr, input logic [SEL_W-1:0] s,
			input logic [ADR_W-1:0] a, input logic [BUS_W-1:0] d);
		last_lat = 0;
		@(negedge clk);
		cyc  = 1'b1;
		stb  = 1'b1;
		we   = wr;
		sel  = s;
		adr  = a;
		wdat = d;
		do begin
			@(negedge clk);
			last_lat++;                               // cycles since the request edge
		end while (!ack && !err && last_lat < WAIT_MAX);
		assert (ack || err)
		else begin
			other_errs++;
			$display("timeout: no ack or err for the cycle at address %h", a);
		end
		last_rd  = rdat;
		last_ack = ack;
		last_err = err;
		cyc = 1'b0;                                   // release, idle for a cycle at least
		stb = 1'b0;
		we  = 1'b0;
	endtask

	// -------------------------------------------------------------------
	// comparing process
	// -------------------------------------------------------------------
	always @(negedge clk) begin : compare
		logic [BUS_W-1:0] g;
		logic [BUS_W-1:0] e;
		string            w;
		while (got_q.size() > 0) begin
			g = got_q.pop_front();
			e = exp_q.pop_front();
			w = what_q.pop_front();
			assert (g === e)
			else begin
				mismatches++;
				$display("mismatch at %0t: %s got %h expected %h", $time, w, g, e);
			end
		end
	end

	// -------------------------------------------------------------------
	// stimulus
	// -------------------------------------------------------------------
	initial begin
		int                    idx [8];
		int                    k;
		logic [BUS_W-1:0]      d;
		logic [SEL_W-1:0]      s;
		logic [ADR_W-1:0]      a;
		logic [NUM_BTNS-1:0]   pat;
		logic [IO_W-1:0]       sval;
		logic [NUM_DIGITS-1:0] lit;   // digits seen lit during the scan
		bus_word_u             wl;
		void'($urandom(1722));
		rst       = 1'b1;
		cyc       = 1'b0;
		stb       = 1'b0;
		we        = 1'b0;
		sel       = '0;
		adr       = '0;
		wdat      = '0;
		sw        = '0;
		btn       = '0;
		btn_model = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// scratch ram, full words first so no byte stays unknown
		for (int i = 0; i < 8; i++) begin
			idx[i] = $urandom % (1 << SCR_ADR_BITS);
			d = rand_word();
			bus_cycle(1'b1, '1, ram_addr(idx[i]), d);
			ram_model[idx[i]] = d;
			queue_check(last_lat, 1, "ram write ack latency");
		end
		for (int i = 0; i < 16; i++) begin
			k = idx[$urandom % 8];
			d = rand_word();
			s = $urandom;
			bus_cycle(1'b1, s, ram_addr(k), d);
			for (int b = 0; b < SEL_W; b++)
				if (s[b])
					ram_model[k][b*8 +: 8] = d[b*8 +: 8];  // merge selected bytes
			queue_check(last_lat, 1, "ram partial write ack latency");
		end
		for (int i = 0; i < 8; i++) begin
			bus_cycle(1'b0, '1, ram_addr(idx[i]), '0);
			queue_check(last_rd, expected_read(ram_addr(idx[i])), "ram read data");
			queue_check(last_lat, 1, "ram read ack latency");
		end

		// leds written per lane, switches read back per lane
		for (int ln = 0; ln < LANES; ln++) begin
			wl.word = rand_word();
			bus_cycle(1'b1, '1, io_addr(LED_OFS, ln), wl.word);
			queue_check(led, wl.lane[ln][15:0], "led output");
			queue_check(last_lat, 2, "led write ack latency");
			sw = $urandom;
			bus_cycle(1'b0, '1, io_addr(LED_OFS, ln), '0);
			queue_check(last_rd, expected_read(io_addr(LED_OFS, ln)), "switch read");
			queue_check(last_lat, 2, "switch read ack latency");
		end

		// buttons, settle then a short glitch
		for (int r = 0; r < 2; r++) begin
			pat = $urandom_range(1, (1 << NUM_BTNS) - 1);
			a   = io_addr(BTN_OFS, $urandom % LANES);
			btn = pat;
			repeat (2 * DEBOUNCE_CYCLES) @(negedge clk);
			btn_model = pat;
			bus_cycle(1'b0, '1, a, '0);
			queue_check(last_rd, expected_read(a), "button read after settle");
			btn = ~pat;                              // too short to pass the filter
			repeat (DEBOUNCE_CYCLES / 4) @(negedge clk);
			bus_cycle(1'b0, '1, a, '0);              // glitch past the sync stages
			queue_check(last_rd, expected_read(a), "button read during glitch");
			btn = pat;
			repeat (4) @(negedge clk);               // sync stages catch up
			bus_cycle(1'b0, '1, a, '0);
			queue_check(last_rd, expected_read(a), "button read after glitch");
		end

		// seven-segment display scan
		sval = $urandom;
		k    = $urandom % LANES;
		wl.word    = rand_word();
		wl.lane[k] = sval;
		bus_cycle(1'b1, '1, io_addr(SSEG_OFS, k), wl.word);
		queue_check(last_lat, 2, "display write ack latency");
		lit = '0;
		for (int c = 0; c < SCAN_LEN; c++) begin
			@(negedge clk);
			queue_check($countones(~an), 1, "anodes low");
			lit |= ~an;
			k = 0;
			for (int j = 0; j < NUM_DIGITS; j++)
				if (!an[j])
					k = j;                           // lit digit
			queue_check(ssg, expected_seg(sval[k*4 +: 4]), "segments for lit digit");
		end
		queue_check(lit, {NUM_DIGITS{1'b1}}, "every digit scanned");
		bus_cycle(1'b0, '1, io_addr(SSEG_OFS, 1), '0);
		queue_check(last_rd, expected_read(io_addr(SSEG_OFS, 1)), "display read");

		// unmapped offset, then outside both windows
		bus_cycle(1'b0, '1, io_addr(8'h42, 0), '0);
		queue_check(last_err, 1, "err on unmapped i/o offset");
		queue_check(last_ack, 0, "no ack on unmapped i/o offset");
		bus_cycle(1'b0, '1, 32'h8000_0000, '0);
		queue_check(last_err, 1, "err outside both regions");
		queue_check(last_ack, 0, "no ack outside both regions");
		bus_cycle(1'b0, '1, ram_addr(idx[0]), '0);   // bus still usable
		queue_check(last_rd, expected_read(ram_addr(idx[0])), "ram read after err");
		bus_cycle(1'b0, '1, io_addr(LED_OFS, 2), '0);
		queue_check(last_rd, expected_read(io_addr(LED_OFS, 2)), "switch read after err");

		for (int t = 0; t < 8 && got_q.size() > 0; t++)
			@(negedge clk);
		assert (got_q.size() == 0)
		else begin
			other_errs++;
			$display("comparison queue still holds %0d entries", got_q.size());
		end
		$display("errors: %0d mismatches, %0d other, %0d assertion", mismatches, other_errs,
			i_dut.i_props.fail_cnt);
		if (mismatches + other_errs + i_dut.i_props.fail_cnt == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule
